//--- logic/hpc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hpc_ctrl import hpc_pkg::*; #(
   parameter int DEPTH_BW = 5
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                nzv_valid,
   input  act_t                nzv_data,
   input  logic                nzv_last,
   input  logic                w_valid,
   input  logic                w_last,
   input  logic                out_ready,
   input  logic [DEPTH_BW:0]   num_rows,
   input  logic                clear_done,
   output logic                nzv_ready,
   output logic                w_ready,
   output logic                rd_en,
   output logic [DEPTH_BW-1:0] rd_addr,
   output logic                wr_en,
   output logic [DEPTH_BW-1:0] wr_addr,
   output logic                op_valid,
   output logic                mode,
   output logic                out_valid,
   output logic                out_last,
   output logic                hold
);

   hpc_state_t          state;
   hpc_state_t          state_nx;
   logic [1:0]          drain_cnt;
   logic [DEPTH_BW-1:0] rd_cnt;
   logic [DEPTH_BW-1:0] wr_cnt;
   logic                rd_all;
   logic                act_zero;
   logic                w_fire;
   logic                nzv_fire;
   logic                out_fire;
   logic                rd_row_last;
   logic                s0_last;

   // Flag pipeline, stage 0 is the accepting cycle
   logic s1_valid, s1_mode, s1_last;
   logic s2_valid, s2_mode, s2_last;

   // ----------------------------------------------------------
   // Stream handshakes
   // ----------------------------------------------------------
   assign act_zero  = (nzv_data == '0);
   assign w_ready   = (state == HPC_MAC) && nzv_valid && !act_zero;
   assign w_fire    = w_valid && w_ready;
   // Zero activation is consumed without a weight column
   assign nzv_ready = (state == HPC_MAC) && ((w_fire && w_last) || act_zero);
   assign nzv_fire  = nzv_valid && nzv_ready;
   assign op_valid  = w_fire;

   assign out_valid = s2_valid && s2_mode;
   assign out_last  = out_valid && s2_last;
   assign hold      = out_valid && !out_ready;
   assign out_fire  = out_valid && out_ready;

   // ----------------------------------------------------------
   // Memory addressing
   // ----------------------------------------------------------
   assign rd_row_last = ({1'b0, rd_cnt} == num_rows - 1'b1);
   assign rd_en       = op_valid || ((state == HPC_READ) && !rd_all && !hold);
   assign s0_last     = (state == HPC_READ) ? rd_row_last : w_last;
   assign rd_addr     = rd_cnt;
   assign wr_addr     = wr_cnt;
   assign wr_en       = s2_valid && !hold;
   assign mode        = s1_mode;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_cnt <= '0;
         wr_cnt <= '0;
      end else begin
         if (rd_en) begin
            rd_cnt <= s0_last ? '0 : rd_cnt + 1'b1;
         end
         if (wr_en) begin
            wr_cnt <= s2_last ? '0 : wr_cnt + 1'b1;
         end
      end
   end

   // Frozen as a whole while the output is stalled
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
         s1_mode  <= 1'b0;
         s1_last  <= 1'b0;
         s2_valid <= 1'b0;
         s2_mode  <= 1'b0;
         s2_last  <= 1'b0;
      end else if (!hold) begin
         s1_valid <= rd_en;
         s1_mode  <= (state == HPC_READ);
         s1_last  <= s0_last;
         s2_valid <= s1_valid;
         s2_mode  <= s1_mode;
         s2_last  <= s1_last;
      end
   end

   // ----------------------------------------------------------
   // State machine
   // ----------------------------------------------------------
   always_comb begin
      state_nx = state;
      case (state)
         HPC_IDLE: begin
            if (clear_done) begin
               state_nx = HPC_MAC;
            end
         end
         HPC_MAC: begin
            if (nzv_fire && nzv_last) begin
               state_nx = HPC_DRAIN;
            end
         end
         HPC_DRAIN: begin
            if (drain_cnt == 2'd2) begin
               state_nx = HPC_READ;
            end
         end
         HPC_READ: begin
            if (out_fire && out_last) begin
               state_nx = HPC_MAC;
            end
         end
         default: state_nx = HPC_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= HPC_IDLE;
         drain_cnt <= '0;
         rd_all    <= 1'b0;
      end else begin
         state     <= state_nx;
         drain_cnt <= (state == HPC_DRAIN) ? drain_cnt + 1'b1 : 2'd0;
         if (out_fire && out_last) begin
            rd_all <= 1'b0;
         end else if (rd_en && (state == HPC_READ) && rd_row_last) begin
            rd_all <= 1'b1;
         end
      end
   end

   // Same row must not come back before its previous sum is written
   assert property (@(posedge clk) disable iff (!rst_n)
      op_valid |-> (num_rows >= 'd3))
      else $error("num_rows below 3 while weights are accepted");

   // Every column wrapped both counters before readout starts
   assert property (@(posedge clk) disable iff (!rst_n)
      $rose(state == HPC_READ) |-> ((rd_cnt == '0) && (wr_cnt == '0)))
      else $error("row counters not back at row 0 when readout starts");

endmodule

`default_nettype wire

//--- logic/hpc_pkg.sv
`default_nettype none

package hpc_pkg;

   // Data widths in fixed point, 8 integer and 8 fraction bits each
   localparam int ACT_BW   = 16;
   localparam int W_BW     = 16;
   localparam int W_FRA_BW = 8;
   localparam int ACC_BW   = ACT_BW + W_BW;

   typedef logic signed [ACT_BW-1:0] act_t;
   typedef logic signed [W_BW-1:0]   weight_t;
   typedef logic signed [ACC_BW-1:0] acc_t;

   // Controller states
   typedef enum logic [1:0] {
      HPC_IDLE  = 2'd0,
      HPC_MAC   = 2'd1,
      HPC_DRAIN = 2'd2,
      HPC_READ  = 2'd3
   } hpc_state_t;

endpackage

`default_nettype wire

//--- logic/hpc_top.sv
`timescale 1ns/1ps
`default_nettype none

module hpc_top import hpc_pkg::*; #(
   parameter int NUM_PE   = 4,
   parameter int DEPTH_BW = 5
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [DEPTH_BW:0]    num_rows,
   // Activation stream
   input  logic                 nzv_valid,
   output logic                 nzv_ready,
   input  act_t                 nzv_data,
   input  logic                 nzv_last,
   // Weight stream
   input  logic                 w_valid,
   output logic                 w_ready,
   input  weight_t [NUM_PE-1:0] w_data,
   input  logic                 w_last,
   // Result stream
   output logic                 out_valid,
   input  logic                 out_ready,
   output act_t    [NUM_PE-1:0] out_data,
   output logic                 out_last
);

   logic                clear_done;
   logic                rd_en;
   logic [DEPTH_BW-1:0] rd_addr;
   logic                wr_en;
   logic [DEPTH_BW-1:0] wr_addr;
   logic                op_valid;
   logic                mode;
   logic                hold;
   acc_t [NUM_PE-1:0]   mem_rd_data;
   acc_t [NUM_PE-1:0]   mem_wr_data;

   hpc_ctrl #(
      .DEPTH_BW (DEPTH_BW)
   ) u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .nzv_valid  (nzv_valid),
      .nzv_data   (nzv_data),
      .nzv_last   (nzv_last),
      .w_valid    (w_valid),
      .w_last     (w_last),
      .out_ready  (out_ready),
      .num_rows   (num_rows),
      .clear_done (clear_done),
      .nzv_ready  (nzv_ready),
      .w_ready    (w_ready),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .op_valid   (op_valid),
      .mode       (mode),
      .out_valid  (out_valid),
      .out_last   (out_last),
      .hold       (hold)
   );

   hpe_array #(
      .NUM_PE (NUM_PE)
   ) u_array (
      .clk         (clk),
      .rst_n       (rst_n),
      .hold        (hold),
      .mode        (mode),
      .op_valid    (op_valid),
      .nzv_data    (nzv_data),
      .w_data      (w_data),
      .mem_rd_data (mem_rd_data),
      .mem_wr_data (mem_wr_data),
      .out_data    (out_data)
   );

   mem_acc #(
      .NUM_PE   (NUM_PE),
      .DEPTH_BW (DEPTH_BW)
   ) u_mem (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (mem_wr_data),
      .rd_data    (mem_rd_data),
      .clear_done (clear_done)
   );

endmodule

`default_nettype wire

//--- logic/hpe_array.sv
`timescale 1ns/1ps
`default_nettype none

module hpe_array import hpc_pkg::*; #(
   parameter int NUM_PE = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 hold,
   input  logic                 mode,
   input  logic                 op_valid,
   input  act_t                 nzv_data,
   input  weight_t [NUM_PE-1:0] w_data,
   input  acc_t    [NUM_PE-1:0] mem_rd_data,
   output acc_t    [NUM_PE-1:0] mem_wr_data,
   output act_t    [NUM_PE-1:0] out_data
);

   // Activation held for one cycle, same as the memory read
   act_t act_d;

   always_ff @(posedge clk) begin
      if (op_valid) begin
         act_d <= nzv_data;
      end
   end

   for (genvar i = 0; i < NUM_PE; i++) begin : g_lane
      hpe_lane u_lane (
         .clk     (clk),
         .rst_n   (rst_n),
         .hold    (hold),
         .mode    (mode),
         .act     (act_d),
         .weight  (w_data[i]),
         .acc_in  (mem_rd_data[i]),
         .acc_out (mem_wr_data[i]),
         .act_out (out_data[i])
      );
   end

endmodule

`default_nettype wire

//--- logic/hpe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module hpe_lane import hpc_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    hold,
   input  logic    mode,
   input  act_t    act,
   input  weight_t weight,
   input  acc_t    acc_in,
   output acc_t    acc_out,
   output act_t    act_out
);

   localparam acc_t ACT_MAX = (1 <<< (ACT_BW - 1)) - 1;
   localparam acc_t ACT_MIN = -(1 <<< (ACT_BW - 1));

   weight_t weight_r;
   acc_t    product;
   acc_t    acc_shift;
   act_t    act_sat;

   // Weight lines up with the memory read data
   always_ff @(posedge clk) begin
      if (!hold) begin
         weight_r <= weight;
      end
   end

   assign product   = acc_t'(act) * acc_t'(weight_r);
   assign acc_shift = acc_in >>> W_FRA_BW;

   // Back to activation format, clipped
   always_comb begin
      if (acc_shift > ACT_MAX) begin
         act_sat = act_t'(ACT_MAX);
      end else if (acc_shift < ACT_MIN) begin
         act_sat = act_t'(ACT_MIN);
      end else begin
         act_sat = act_t'(acc_shift);
      end
   end

   // Readout writes zero back, which clears the row
   always_ff @(posedge clk) begin
      if (!hold) begin
         acc_out <= mode ? '0 : acc_in + product;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         act_out <= '0;
      end else if (mode && !hold) begin
         act_out <= act_sat;
      end
   end

endmodule

`default_nettype wire

//--- logic/mem_acc.sv
`timescale 1ns/1ps
`default_nettype none

module mem_acc import hpc_pkg::*; #(
   parameter int NUM_PE   = 4,
   parameter int DEPTH_BW = 5
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                rd_en,
   input  logic [DEPTH_BW-1:0] rd_addr,
   input  logic                wr_en,
   input  logic [DEPTH_BW-1:0] wr_addr,
   input  acc_t [NUM_PE-1:0]   wr_data,
   output acc_t [NUM_PE-1:0]   rd_data,
   output logic                clear_done
);

   localparam int DEPTH = 1 << DEPTH_BW;

   acc_t [NUM_PE-1:0]   mem_q [DEPTH];
   logic [DEPTH_BW-1:0] clear_addr;

   // ----------------------------------------------------------
   // Clear sweep over all rows
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clear_addr <= '0;
         clear_done <= 1'b0;
      end else if (!clear_done) begin
         clear_addr <= clear_addr + 1'b1;
         if (clear_addr == '1) begin
            clear_done <= 1'b1;
         end
      end
   end

   // Sweep owns the write port until it is done
   always_ff @(posedge clk) begin
      if (!clear_done) begin
         mem_q[clear_addr] <= '0;
      end else if (wr_en) begin
         mem_q[wr_addr] <= wr_data;
      end
   end

   // Read data holds when no read is issued
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem_q[rd_addr];
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      (rd_en && wr_en) |-> (rd_addr != wr_addr))
      else $error("accumulation row read and written in the same cycle");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then search the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module tb_hpc -Mdir "$BUILD_DIR" -o tb_hpc
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_hpc" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
   echo "Simulation exited with an error status"
   exit 1
fi

if grep -qx "sim passed" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim.f
logic/hpc_pkg.sv
logic/hpc_ctrl.sv
logic/hpe_lane.sv
logic/hpe_array.sv
logic/mem_acc.sv
logic/hpc_top.sv
tb/hpc_checker.sv
tb/tb_hpc.sv

//--- tb/hpc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hpc_checker import hpc_pkg::*; #(
   parameter int NUM_PE   = 4,
   parameter int DEPTH_BW = 5
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  int                   test_id,
   input  logic [DEPTH_BW:0]    num_rows,
   input  logic                 nzv_valid,
   input  logic                 nzv_ready,
   input  act_t                 nzv_data,
   input  logic                 nzv_last,
   input  logic                 w_valid,
   input  logic                 w_ready,
   input  weight_t [NUM_PE-1:0] w_data,
   input  logic                 w_last,
   input  logic                 out_valid,
   input  logic                 out_ready,
   input  act_t    [NUM_PE-1:0] out_data,
   input  logic                 out_last,
   output int                   data_errors,
   output int                   proto_errors,
   output int                   vectors_out,
   output int                   clip_hi,
   output int                   clip_lo
);

   localparam int     DEPTH   = 1 << DEPTH_BW;
   localparam longint ACT_MAX = (longint'(1) <<< (ACT_BW - 1)) - 1;
   localparam longint ACT_MIN = -(longint'(1) <<< (ACT_BW - 1));

   // Full width sums, one per row and lane
   longint              model [DEPTH][NUM_PE];
   int                  w_row;
   int                  out_row;
   int                  vectors_in;
   logic                stalled;
   act_t [NUM_PE-1:0]   held_data;
   logic                held_last;

   function automatic string test_name(input int id);
      case (id)
         0:       return "dense";
         1:       return "sparse";
         2:       return "saturate";
         3:       return "stall";
         default: return "unknown";
      endcase
   endfunction

   // Drop the weight fraction bits, then clip to the activation range
   function automatic longint rescale(input longint sum);
      longint s;
      s = sum >>> W_FRA_BW;
      if (s > ACT_MAX) begin
         return ACT_MAX;
      end
      if (s < ACT_MIN) begin
         return ACT_MIN;
      end
      return s;
   endfunction

   // ----------------------------------------------------------
   // Handshakes sampled mid cycle, where they are stable
   // ----------------------------------------------------------
   always @(negedge clk) begin
      longint exp_val;
      longint shifted;
      int     r;
      int     l;
      if (!rst_n) begin
         for (r = 0; r < DEPTH; r++) begin
            for (l = 0; l < NUM_PE; l++) begin
               model[r][l] = 0;
            end
         end
         w_row        = 0;
         out_row      = 0;
         vectors_in   = 0;
         stalled      = 1'b0;
         held_data    = '0;
         held_last    = 1'b0;
         data_errors  = 0;
         proto_errors = 0;
         vectors_out  = 0;
         clip_hi      = 0;
         clip_lo      = 0;
      end else begin
         if (nzv_valid && (nzv_data == '0) && w_ready) begin
            $display("Protocol error in %s: weight ready high for a zero activation",
                     test_name(test_id));
            proto_errors++;
         end
         if (w_valid && w_ready) begin
            if (!nzv_valid || (nzv_data == '0)) begin
               $display("Protocol error in %s: weight beat taken without a nonzero activation",
                        test_name(test_id));
               proto_errors++;
            end
            for (l = 0; l < NUM_PE; l++) begin
               model[w_row][l] += longint'($signed(nzv_data)) * longint'($signed(w_data[l]));
            end
            w_row = w_last ? 0 : (w_row + 1) % DEPTH;
         end
         // A nonzero activation leaves only with the end of its column
         if (nzv_valid && nzv_ready && (nzv_data != '0) && !(w_valid && w_ready && w_last)) begin
            $display("Protocol error in %s: activation consumed before its column ended",
                     test_name(test_id));
            proto_errors++;
         end
         if (nzv_valid && nzv_ready && nzv_last) begin
            vectors_in++;
         end
         if (stalled && (!out_valid || (out_data != held_data) || (out_last != held_last))) begin
            $display("Protocol error in %s: output changed while out_ready was low",
                     test_name(test_id));
            proto_errors++;
         end
         if (out_valid && out_ready) begin
            if (vectors_out >= vectors_in) begin
               $display("Protocol error in %s: output beat with no input vector pending",
                        test_name(test_id));
               proto_errors++;
            end
            for (l = 0; l < NUM_PE; l++) begin
               shifted = model[out_row][l] >>> W_FRA_BW;
               exp_val = rescale(model[out_row][l]);
               if (shifted > ACT_MAX) begin
                  clip_hi++;
               end
               if (shifted < ACT_MIN) begin
                  clip_lo++;
               end
               if (act_t'(exp_val) != out_data[l]) begin
                  $display("** Error [%s] row %0d lane %0d: expected %0d, actual %0d",
                           test_name(test_id), out_row, l, exp_val, $signed(out_data[l]));
                  data_errors++;
               end
               model[out_row][l] = 0;
            end
            if (out_last != (out_row == int'(num_rows) - 1)) begin
               $display("** Error [%s] out_last on row %0d: expected %0b, actual %0b",
                        test_name(test_id), out_row, out_row == int'(num_rows) - 1, out_last);
               data_errors++;
            end
            if (out_last) begin
               out_row = 0;
               vectors_out++;
            end else begin
               out_row = (out_row + 1) % DEPTH;
            end
         end
         stalled   = out_valid && !out_ready;
         held_data = out_data;
         held_last = out_last;
      end
   end

endmodule

`default_nettype wire

//--- tb/tb_hpc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hpc import hpc_pkg::*; ();

   localparam int NUM_PE    = 4;
   localparam int DEPTH_BW  = 5;
   localparam int RW        = DEPTH_BW + 1;
   localparam int NUM_TESTS = 4;
   localparam int NUM_VEC   = 5;
   localparam int MAX_ACTS  = 10;
   localparam int MIN_ROWS  = 3;
   localparam int MAX_ROWS  = 8;
   localparam int CLK_NS    = 4;
   // Worst case beats over all tests, 20 cycles each, plus reset and clear sweep
   localparam int MAX_BEATS   = NUM_TESTS * NUM_VEC * (MAX_ACTS * (MAX_ROWS + 1) + MAX_ROWS);
   localparam int WATCHDOG_NS = (MAX_BEATS * 20 + 200) * CLK_NS;

   logic                 clk;
   logic                 rst_n;
   logic [DEPTH_BW:0]    num_rows;
   logic                 nzv_valid;
   logic                 nzv_ready;
   act_t                 nzv_data;
   logic                 nzv_last;
   logic                 w_valid;
   logic                 w_ready;
   weight_t [NUM_PE-1:0] w_data;
   logic                 w_last;
   logic                 out_valid;
   logic                 out_ready;
   act_t    [NUM_PE-1:0] out_data;
   logic                 out_last;

   int test_id;
   int data_errors;
   int proto_errors;
   int tb_errors;
   int vectors_out;
   int vectors_sent;
   int clip_hi;
   int clip_lo;
   int seed;
   int valid_pct;
   int ready_pct;

   // Stimulus of the vector in flight
   act_t                 act_q [$];
   weight_t [NUM_PE-1:0] w_q [$];
   logic                 w_last_q [$];

   hpc_top #(
      .NUM_PE   (NUM_PE),
      .DEPTH_BW (DEPTH_BW)
   ) uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .num_rows  (num_rows),
      .nzv_valid (nzv_valid),
      .nzv_ready (nzv_ready),
      .nzv_data  (nzv_data),
      .nzv_last  (nzv_last),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .w_data    (w_data),
      .w_last    (w_last),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_last  (out_last)
   );

   hpc_checker #(
      .NUM_PE   (NUM_PE),
      .DEPTH_BW (DEPTH_BW)
   ) watcher (
      .clk          (clk),
      .rst_n        (rst_n),
      .test_id      (test_id),
      .num_rows     (num_rows),
      .nzv_valid    (nzv_valid),
      .nzv_ready    (nzv_ready),
      .nzv_data     (nzv_data),
      .nzv_last     (nzv_last),
      .w_valid      (w_valid),
      .w_ready      (w_ready),
      .w_data       (w_data),
      .w_last       (w_last),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_data     (out_data),
      .out_last     (out_last),
      .data_errors  (data_errors),
      .proto_errors (proto_errors),
      .vectors_out  (vectors_out),
      .clip_hi      (clip_hi),
      .clip_lo      (clip_lo)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("sim failed");
      $finish;
   end

   // ----------------------------------------------------------
   // Random helpers
   // ----------------------------------------------------------
   function automatic int rand_range(input int lo, input int hi);
      int unsigned r;
      r = $random(seed);
      return lo + int'(r % (hi - lo + 1));
   endfunction

   function automatic bit chance(input int pct);
      return rand_range(0, 99) < pct;
   endfunction

   function automatic int signed_value(input int lo_mag, input int hi_mag);
      int mag;
      mag = rand_range(lo_mag, hi_mag);
      return chance(50) ? -mag : mag;
   endfunction

   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   // ----------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------
   task automatic build_vector(input int zero_pct, input int act_lo, input int act_hi,
                               input int w_hi);
      int                   n_act;
      int                   i;
      int                   r;
      int                   l;
      act_t                 a;
      weight_t [NUM_PE-1:0] beat;
      act_q.delete();
      w_q.delete();
      w_last_q.delete();
      n_act = rand_range(1, MAX_ACTS);
      for (i = 0; i < n_act; i++) begin
         if (chance(zero_pct)) begin
            a = '0;
         end else begin
            a = act_t'(signed_value(act_lo, act_hi));
         end
         act_q.push_back(a);
         // Zero activations get no column
         if (a != '0) begin
            for (r = 0; r < int'(num_rows); r++) begin
               for (l = 0; l < NUM_PE; l++) begin
                  beat[l] = weight_t'(signed_value(0, w_hi));
               end
               w_q.push_back(beat);
               w_last_q.push_back(r == int'(num_rows) - 1);
            end
         end
      end
   endtask

   task automatic send_vector;
      int ai;
      int wi;
      bit a_fire;
      bit w_fire;
      ai = 0;
      wi = 0;
      while ((ai < act_q.size()) || (wi < w_q.size())) begin
         if (!nzv_valid && (ai < act_q.size()) && chance(valid_pct)) begin
            nzv_valid = 1'b1;
            nzv_data  = act_q[ai];
            nzv_last  = (ai == act_q.size() - 1);
         end
         if (!w_valid && (wi < w_q.size()) && chance(valid_pct)) begin
            w_valid = 1'b1;
            w_data  = w_q[wi];
            w_last  = w_last_q[wi];
         end
         out_ready = chance(ready_pct);
         @(negedge clk);
         a_fire = nzv_valid && nzv_ready;
         w_fire = w_valid && w_ready;
         next_cycle();
         if (a_fire) begin
            nzv_valid = 1'b0;
            ai++;
         end
         if (w_fire) begin
            w_valid = 1'b0;
            wi++;
         end
      end
   endtask

   task automatic collect_outputs;
      while (vectors_out < vectors_sent) begin
         out_ready = chance(ready_pct);
         next_cycle();
      end
      out_ready = 1'b0;
   endtask

   task automatic wait_ready(output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; (n < 200) && !ok; n++) begin
         @(negedge clk);
         ok = nzv_ready;
      end
      next_cycle();
   endtask

   task automatic run_test(input int id, input string name, input int zero_pct,
                           input int act_lo, input int act_hi, input int w_hi,
                           input int v_pct, input int r_pct);
      int v;
      test_id   = id;
      valid_pct = v_pct;
      ready_pct = r_pct;
      $display("Running test %s", name);
      for (v = 0; v < NUM_VEC; v++) begin
         num_rows = RW'(rand_range(MIN_ROWS, MAX_ROWS));
         build_vector(zero_pct, act_lo, act_hi, w_hi);
         send_vector();
         vectors_sent++;
         collect_outputs();
      end
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      bit ready_seen;
      int hi_before;
      int lo_before;
      seed         = 32'hf8c1;
      rst_n        = 1'b0;
      num_rows     = RW'(MIN_ROWS);
      nzv_valid    = 1'b0;
      nzv_data     = '0;
      nzv_last     = 1'b0;
      w_valid      = 1'b0;
      w_data       = '0;
      w_last       = 1'b0;
      out_ready    = 1'b0;
      test_id      = 0;
      tb_errors    = 0;
      vectors_sent = 0;
      valid_pct    = 0;
      ready_pct    = 0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // Controller sits in idle until the memory clear sweep ends
      wait_ready(ready_seen);
      if (!ready_seen) begin
         $display("Controller never accepted input after reset");
         tb_errors++;
      end else begin
         run_test(0, "dense", 0, 1, 512, 512, 80, 90);
         run_test(1, "sparse", 30, 1, 512, 512, 70, 70);
         hi_before = clip_hi;
         lo_before = clip_lo;
         run_test(2, "saturate", 20, 4096, 8191, 4096, 80, 80);
         if ((clip_hi == hi_before) || (clip_lo == lo_before)) begin
            $display("Saturation test did not reach both the maximum and the minimum");
            tb_errors++;
         end
         run_test(3, "stall", 30, 1, 512, 512, 60, 25);
      end
      repeat (4) next_cycle();
      $display("Errors: data %0d, protocol %0d, testbench %0d",
               data_errors, proto_errors, tb_errors);
      if ((data_errors + proto_errors + tb_errors) == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
